// File: Makefile
BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build output and the log"

test:
	verilator --binary --timing --assert --top-module tb_fetch_top \
		--Mdir $(BUILD) -o sim -f list.f
	./$(BUILD)/sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '*** PASSED ***' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: design/bank_router.sv
module bank_router #(
    parameter int INDEX_WIDTH = bpred_pkg::DEFAULT_INDEX_WIDTH,
    parameter int BANK_BITS   = bpred_pkg::DEFAULT_BANK_BITS
) (
    input  fetch_pkg::addr_t                     lookup_pc_i,
    input  logic                                 resolve_valid_i,
    input  fetch_pkg::addr_t                     resolve_pc_i,
    input  logic                                 resolve_taken_i,
    input  fetch_pkg::addr_t                     resolve_target_i,
    output logic [INDEX_WIDTH-1:0]               lookup_index_o,
    output logic [fetch_pkg::ADDR_WIDTH-fetch_pkg::WORD_OFFSET_BITS-BANK_BITS-INDEX_WIDTH-1:0]
                                                 lookup_tag_o,
    output logic [INDEX_WIDTH-1:0]               upd_index_o,
    output logic [fetch_pkg::ADDR_WIDTH-fetch_pkg::WORD_OFFSET_BITS-BANK_BITS-INDEX_WIDTH-1:0]
                                                 upd_tag_o,
    output fetch_pkg::addr_t                     upd_target_o,
    output logic                                 upd_taken_o,
    output logic [(1 << BANK_BITS)-1:0]          upd_en_o
);

    // Field positions, from the word offset upward
    localparam int BANK_LSB  = fetch_pkg::WORD_OFFSET_BITS;
    localparam int INDEX_LSB = BANK_LSB + BANK_BITS;
    localparam int TAG_LSB   = INDEX_LSB + INDEX_WIDTH;
    localparam int TAG_WIDTH = fetch_pkg::ADDR_WIDTH - TAG_LSB;

    logic [BANK_BITS-1:0] upd_bank;

    // Lookup side
    assign lookup_index_o = lookup_pc_i[INDEX_LSB +: INDEX_WIDTH];
    assign lookup_tag_o   = lookup_pc_i[TAG_LSB +: TAG_WIDTH];

    // Update side
    assign upd_bank     = resolve_pc_i[BANK_LSB +: BANK_BITS];
    assign upd_index_o  = resolve_pc_i[INDEX_LSB +: INDEX_WIDTH];
    assign upd_tag_o    = resolve_pc_i[TAG_LSB +: TAG_WIDTH];
    assign upd_target_o = resolve_target_i;
    assign upd_taken_o  = resolve_taken_i;

    // One-hot bank write enable, only on a resolve strobe
    always_comb begin
        upd_en_o = '0;
        if (resolve_valid_i) begin
            upd_en_o[upd_bank] = 1'b1;
        end
        assert ($onehot0(upd_en_o))
            else $error("bank_router: more than one bank enabled");
        assert (!resolve_valid_i || (upd_en_o != '0))
            else $error("bank_router: resolve strobe reached no bank");
    end

endmodule

// File: design/bpred_pkg.sv
package bpred_pkg;

    // Two-bit saturating direction counter
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } ctr_t;

    // New entries start weakly taken
    localparam ctr_t CTR_ALLOC = WEAK_T;

    // Index bits inside one bank
    localparam int DEFAULT_INDEX_WIDTH = 4;

    // log2 of the number of banks
    localparam int DEFAULT_BANK_BITS = 1;

endpackage

// File: design/fetch_pkg.sv
package fetch_pkg;

    // Instruction address geometry
    localparam int ADDR_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // One instruction word per fetch
    localparam addr_t INSTR_BYTES = 32'd4;

    // First fetch address out of reset
    localparam addr_t RESET_VECTOR = 32'h0000_0000;

    // Byte offset within a word, ignored by the predictor
    localparam int WORD_OFFSET_BITS = 2;

endpackage

// File: design/fetch_top.sv
module fetch_top #(
    parameter int INDEX_WIDTH = bpred_pkg::DEFAULT_INDEX_WIDTH,
    parameter int BANK_BITS   = bpred_pkg::DEFAULT_BANK_BITS
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             stall_i,
    input  logic             resolve_valid_i,
    input  fetch_pkg::addr_t resolve_pc_i,
    input  logic             resolve_taken_i,
    input  logic             resolve_pred_i,
    input  fetch_pkg::addr_t resolve_target_i,
    output fetch_pkg::addr_t fetch_pc_o,
    output logic             pred_taken_o,
    output logic             flush_o
);

    localparam int NUM_BANKS = 1 << BANK_BITS;
    localparam int TAG_WIDTH = fetch_pkg::ADDR_WIDTH - fetch_pkg::WORD_OFFSET_BITS
                               - BANK_BITS - INDEX_WIDTH;

    fetch_pkg::addr_t                   lookup_pc;
    logic [INDEX_WIDTH-1:0]             lookup_index;
    logic [TAG_WIDTH-1:0]               lookup_tag;
    logic [INDEX_WIDTH-1:0]             upd_index;
    logic [TAG_WIDTH-1:0]               upd_tag;
    fetch_pkg::addr_t                   upd_target;
    logic                               upd_taken;
    logic [NUM_BANKS-1:0]               upd_en;
    logic [NUM_BANKS-1:0]               bank_hit;
    bpred_pkg::ctr_t [NUM_BANKS-1:0]    bank_ctr;
    fetch_pkg::addr_t [NUM_BANKS-1:0]   bank_target;

    bank_router #(
        .INDEX_WIDTH (INDEX_WIDTH),
        .BANK_BITS   (BANK_BITS)
    ) bank_router_i (
        .lookup_pc_i      (lookup_pc),
        .resolve_valid_i  (resolve_valid_i),
        .resolve_pc_i     (resolve_pc_i),
        .resolve_taken_i  (resolve_taken_i),
        .resolve_target_i (resolve_target_i),
        .lookup_index_o   (lookup_index),
        .lookup_tag_o     (lookup_tag),
        .upd_index_o      (upd_index),
        .upd_tag_o        (upd_tag),
        .upd_target_o     (upd_target),
        .upd_taken_o      (upd_taken),
        .upd_en_o         (upd_en)
    );

    // Banks share lookup and update fields, each takes its own write enable
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        predictor_bank #(
            .INDEX_WIDTH (INDEX_WIDTH),
            .TAG_WIDTH   (TAG_WIDTH)
        ) predictor_bank_i (
            .clk_i          (clk_i),
            .rst_i          (rst_i),
            .lookup_index_i (lookup_index),
            .lookup_tag_i   (lookup_tag),
            .upd_en_i       (upd_en[b]),
            .upd_index_i    (upd_index),
            .upd_tag_i      (upd_tag),
            .upd_target_i   (upd_target),
            .upd_taken_i    (upd_taken),
            .hit_o          (bank_hit[b]),
            .ctr_o          (bank_ctr[b]),
            .target_o       (bank_target[b])
        );
    end

    pc_unit #(
        .BANK_BITS (BANK_BITS)
    ) pc_unit_i (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stall_i          (stall_i),
        .bank_hit_i       (bank_hit),
        .bank_ctr_i       (bank_ctr),
        .bank_target_i    (bank_target),
        .resolve_valid_i  (resolve_valid_i),
        .resolve_pc_i     (resolve_pc_i),
        .resolve_taken_i  (resolve_taken_i),
        .resolve_pred_i   (resolve_pred_i),
        .resolve_target_i (resolve_target_i),
        .lookup_pc_o      (lookup_pc),
        .fetch_pc_o       (fetch_pc_o),
        .pred_taken_o     (pred_taken_o),
        .flush_o          (flush_o)
    );

endmodule

// File: design/pc_unit.sv
module pc_unit #(
    parameter int BANK_BITS = bpred_pkg::DEFAULT_BANK_BITS
) (
    input  logic                                       clk_i,
    input  logic                                       rst_i,
    input  logic                                       stall_i,
    input  logic [(1 << BANK_BITS)-1:0]                bank_hit_i,
    input  bpred_pkg::ctr_t [(1 << BANK_BITS)-1:0]     bank_ctr_i,
    input  fetch_pkg::addr_t [(1 << BANK_BITS)-1:0]    bank_target_i,
    input  logic                                       resolve_valid_i,
    input  fetch_pkg::addr_t                           resolve_pc_i,
    input  logic                                       resolve_taken_i,
    input  logic                                       resolve_pred_i,
    input  fetch_pkg::addr_t                           resolve_target_i,
    output fetch_pkg::addr_t                           lookup_pc_o,
    output fetch_pkg::addr_t                           fetch_pc_o,
    output logic                                       pred_taken_o,
    output logic                                       flush_o
);

    fetch_pkg::addr_t     pc_q;
    fetch_pkg::addr_t     pc_next;
    fetch_pkg::addr_t     pc_plus4;
    fetch_pkg::addr_t     correction;
    logic [BANK_BITS-1:0] bank_sel;
    logic                 sel_hit;
    bpred_pkg::ctr_t      sel_ctr;
    fetch_pkg::addr_t     sel_target;

    assign lookup_pc_o = pc_q;
    assign fetch_pc_o  = pc_q;
    assign pc_plus4    = pc_q + fetch_pkg::INSTR_BYTES;

    // Pick the bank that owns the current PC
    assign bank_sel   = pc_q[fetch_pkg::WORD_OFFSET_BITS +: BANK_BITS];
    assign sel_hit    = bank_hit_i[bank_sel];
    assign sel_ctr    = bank_ctr_i[bank_sel];
    assign sel_target = bank_target_i[bank_sel];

    // Taken when the entry hits and the counter leans taken
    assign pred_taken_o = sel_hit && sel_ctr[1];

    // Direction mismatch only
    assign flush_o = resolve_valid_i && (resolve_pred_i != resolve_taken_i);

    assign correction = resolve_taken_i ? resolve_target_i
                                        : resolve_pc_i + fetch_pkg::INSTR_BYTES;

    // Flush wins over stall
    always_comb begin
        if (flush_o) begin
            pc_next = correction;
        end else if (stall_i) begin
            pc_next = pc_q;
        end else if (pred_taken_o) begin
            pc_next = sel_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            pc_q <= fetch_pkg::RESET_VECTOR;
        end else begin
            pc_q <= pc_next;
        end
    end

    a_flush_on_resolve: assert property (@(posedge clk_i) disable iff (rst_i)
        flush_o |-> resolve_valid_i)
        else $error("pc_unit: flush without a resolved branch");

endmodule

// File: design/predictor_bank.sv
module predictor_bank #(
    parameter int INDEX_WIDTH = bpred_pkg::DEFAULT_INDEX_WIDTH,
    parameter int TAG_WIDTH   = fetch_pkg::ADDR_WIDTH - fetch_pkg::WORD_OFFSET_BITS
                                - bpred_pkg::DEFAULT_BANK_BITS
                                - bpred_pkg::DEFAULT_INDEX_WIDTH
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic [INDEX_WIDTH-1:0] lookup_index_i,
    input  logic [TAG_WIDTH-1:0]   lookup_tag_i,
    input  logic                   upd_en_i,
    input  logic [INDEX_WIDTH-1:0] upd_index_i,
    input  logic [TAG_WIDTH-1:0]   upd_tag_i,
    input  fetch_pkg::addr_t       upd_target_i,
    input  logic                   upd_taken_i,
    output logic                   hit_o,
    output bpred_pkg::ctr_t        ctr_o,
    output fetch_pkg::addr_t       target_o
);

    localparam int DEPTH = 1 << INDEX_WIDTH;

    logic [DEPTH-1:0]     valid_q;
    logic [TAG_WIDTH-1:0] tag_q    [DEPTH];
    fetch_pkg::addr_t     target_q [DEPTH];
    bpred_pkg::ctr_t      ctr_q    [DEPTH];

    logic            upd_hit;
    logic            upd_alloc;
    bpred_pkg::ctr_t upd_ctr;
    bpred_pkg::ctr_t ctr_next;

    // Combinational read for the fetch PC
    assign hit_o    = valid_q[lookup_index_i] && (tag_q[lookup_index_i] == lookup_tag_i);
    assign ctr_o    = ctr_q[lookup_index_i];
    assign target_o = target_q[lookup_index_i];

    // Does the resolved branch already own its entry
    assign upd_hit   = valid_q[upd_index_i] && (tag_q[upd_index_i] == upd_tag_i);
    assign upd_alloc = upd_en_i && !upd_hit && upd_taken_i;
    assign upd_ctr   = ctr_q[upd_index_i];

    // Saturating counter step
    always_comb begin
        ctr_next = upd_ctr;
        if (upd_taken_i) begin
            if (upd_ctr != bpred_pkg::STRONG_T) begin
                ctr_next = bpred_pkg::ctr_t'(upd_ctr + 2'b01);
            end
        end else begin
            if (upd_ctr != bpred_pkg::STRONG_NT) begin
                ctr_next = bpred_pkg::ctr_t'(upd_ctr - 2'b01);
            end
        end
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (upd_alloc) begin
            valid_q[upd_index_i] <= 1'b1;
        end
    end

    // Entry payload
    always_ff @(posedge clk_i) begin
        if (upd_en_i && upd_hit) begin
            ctr_q[upd_index_i] <= ctr_next;
            if (upd_taken_i) begin
                target_q[upd_index_i] <= upd_target_i;
            end
        end else if (upd_alloc) begin
            // Taken miss replaces whatever was there
            tag_q[upd_index_i]    <= upd_tag_i;
            target_q[upd_index_i] <= upd_target_i;
            ctr_q[upd_index_i]    <= bpred_pkg::CTR_ALLOC;
        end
    end

    // A hit must expose a counter and target written by an earlier allocation
    a_hit_has_entry: assert property (@(posedge clk_i) disable iff (rst_i)
        hit_o |-> valid_q[lookup_index_i] && !$isunknown(ctr_o) && !$isunknown(target_o))
        else $error("predictor_bank: hit on an entry that was never written");

endmodule

// File: list.f
+incdir+test
design/fetch_pkg.sv
design/bpred_pkg.sv
design/bank_router.sv
design/predictor_bank.sv
design/pc_unit.sv
design/fetch_top.sv
test/tb_fetch_top.sv

// File: test/tb_fetch_cases.svh
`ifndef TB_FETCH_CASES_SVH
`define TB_FETCH_CASES_SVH

// Columns are name, stall, resolve valid, resolve pc, taken, pred and target,
// then expected flush, and the PC and prediction after the rising edge
function automatic void load_cases();
    add_row("step_0",          1'b0, 1'b0, 32'h0,   1'b0, 1'b0, 32'h0,   1'b0, 32'h8,   1'b0);
    add_row("step_1",          1'b0, 1'b0, 32'h0,   1'b0, 1'b0, 32'h0,   1'b0, 32'hc,   1'b0);
    add_row("stall_hold",      1'b1, 1'b0, 32'h0,   1'b0, 1'b0, 32'h0,   1'b0, 32'hc,   1'b0);
    add_row("stall_hold_2",    1'b1, 1'b0, 32'h0,   1'b0, 1'b0, 32'h0,   1'b0, 32'hc,   1'b0);
    // Taken miss under stall still redirects and allocates
    add_row("stall_flush",     1'b1, 1'b1, 32'h40,  1'b1, 1'b0, 32'h30,  1'b1, 32'h30,  1'b0);
    add_row("walk_34",         1'b0, 1'b0, 32'h0,   1'b0, 1'b0, 32'h0,   1'b0, 32'h34,  1'b0);
    add_row("walk_38",         1'b0, 1'b0, 32'h0,   1'b0, 1'b0, 32'h0,   1'b0, 32'h38,  1'b0);
    add_row("walk_3c",         1'b0, 1'b0, 32'h0,   1'b0, 1'b0, 32'h0,   1'b0, 32'h3c,  1'b0);
    add_row("reach_branch",    1'b0, 1'b0, 32'h0,   1'b0, 1'b0, 32'h0,   1'b0, 32'h40,  1'b1);
    add_row("pred_taken",      1'b0, 1'b0, 32'h0,   1'b0, 1'b0, 32'h0,   1'b0, 32'h30,  1'b0);
    // Wrong taken prediction, counter drops to weakly not taken
    add_row("nt_flush",        1'b0, 1'b1, 32'h40,  1'b0, 1'b1, 32'h30,  1'b1, 32'h44,  1'b0);
    add_row("to_40_weak_nt",   1'b0, 1'b1, 32'h3c,  1'b0, 1'b1, 32'h0,   1'b1, 32'h40,  1'b0);
    add_row("weak_nt_step",    1'b0, 1'b0, 32'h0,   1'b0, 1'b0, 32'h0,   1'b0, 32'h44,  1'b0);
    add_row("retrain_1",       1'b0, 1'b1, 32'h40,  1'b1, 1'b0, 32'h30,  1'b1, 32'h30,  1'b0);
    add_row("retrain_2",       1'b0, 1'b1, 32'h40,  1'b1, 1'b1, 32'h30,  1'b0, 32'h34,  1'b0);
    add_row("walk_38_b",       1'b0, 1'b0, 32'h0,   1'b0, 1'b0, 32'h0,   1'b0, 32'h38,  1'b0);
    add_row("walk_3c_b",       1'b0, 1'b0, 32'h0,   1'b0, 1'b0, 32'h0,   1'b0, 32'h3c,  1'b0);
    add_row("reach_strong",    1'b0, 1'b0, 32'h0,   1'b0, 1'b0, 32'h0,   1'b0, 32'h40,  1'b1);
    add_row("strong_taken",    1'b0, 1'b0, 32'h0,   1'b0, 1'b0, 32'h0,   1'b0, 32'h30,  1'b0);
    // Same index in bank 1, then a tag conflict in bank 0
    add_row("alloc_bank1",     1'b0, 1'b1, 32'h44,  1'b1, 1'b0, 32'h60,  1'b1, 32'h60,  1'b0);
    add_row("to_40_bank0",     1'b0, 1'b1, 32'h3c,  1'b0, 1'b1, 32'h0,   1'b1, 32'h40,  1'b1);
    add_row("bank0_kept",      1'b0, 1'b0, 32'h0,   1'b0, 1'b0, 32'h0,   1'b0, 32'h30,  1'b0);
    add_row("to_44_bank1",     1'b0, 1'b1, 32'h400, 1'b1, 1'b0, 32'h44,  1'b1, 32'h44,  1'b1);
    add_row("bank1_kept",      1'b0, 1'b0, 32'h0,   1'b0, 1'b0, 32'h0,   1'b0, 32'h60,  1'b0);
    add_row("replace_bank0",   1'b0, 1'b1, 32'hc0,  1'b1, 1'b0, 32'h100, 1'b1, 32'h100, 1'b0);
    add_row("to_40_replaced",  1'b0, 1'b1, 32'h3c,  1'b0, 1'b1, 32'h0,   1'b1, 32'h40,  1'b0);
    add_row("old_entry_miss",  1'b0, 1'b0, 32'h0,   1'b0, 1'b0, 32'h0,   1'b0, 32'h44,  1'b1);
    add_row("bank1_taken",     1'b0, 1'b0, 32'h0,   1'b0, 1'b0, 32'h0,   1'b0, 32'h60,  1'b0);
    add_row("to_c0",           1'b0, 1'b1, 32'hbc,  1'b0, 1'b1, 32'h0,   1'b1, 32'hc0,  1'b1);
    add_row("new_entry_taken", 1'b0, 1'b0, 32'h0,   1'b0, 1'b0, 32'h0,   1'b0, 32'h100, 1'b0);
    add_row("stall_no_flush",  1'b1, 1'b1, 32'h44,  1'b1, 1'b1, 32'h60,  1'b0, 32'h100, 1'b0);
endfunction

`endif

// File: test/tb_fetch_top.sv
module tb_fetch_top;

    localparam int RESET_TIMEOUT = 20;

    typedef struct packed {
        logic             stall;
        logic             valid;
        fetch_pkg::addr_t pc;
        logic             taken;
        logic             pred;
        fetch_pkg::addr_t target;
        logic             exp_flush;
        fetch_pkg::addr_t exp_pc;
        logic             exp_pred;
    } case_t;

    logic             clk_i;
    logic             rst_i;
    logic             stall_i;
    logic             resolve_valid_i;
    fetch_pkg::addr_t resolve_pc_i;
    logic             resolve_taken_i;
    logic             resolve_pred_i;
    fetch_pkg::addr_t resolve_target_i;
    fetch_pkg::addr_t fetch_pc_o;
    logic             pred_taken_o;
    logic             flush_o;

    case_t cases[$];
    string case_names[$];
    int    tests_run;
    int    tests_failed;

    function automatic void add_row(string name, bit stall, bit valid, fetch_pkg::addr_t pc,
                                    bit taken, bit pred, fetch_pkg::addr_t target,
                                    bit exp_flush, fetch_pkg::addr_t exp_pc, bit exp_pred);
        case_t c;
        c.stall     = stall;
        c.valid     = valid;
        c.pc        = pc;
        c.taken     = taken;
        c.pred      = pred;
        c.target    = target;
        c.exp_flush = exp_flush;
        c.exp_pc    = exp_pc;
        c.exp_pred  = exp_pred;
        cases.push_back(c);
        case_names.push_back(name);
    endfunction

    `include "tb_fetch_cases.svh"

    fetch_top fetch_top_i (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stall_i          (stall_i),
        .resolve_valid_i  (resolve_valid_i),
        .resolve_pc_i     (resolve_pc_i),
        .resolve_taken_i  (resolve_taken_i),
        .resolve_pred_i   (resolve_pred_i),
        .resolve_target_i (resolve_target_i),
        .fetch_pc_o       (fetch_pc_o),
        .pred_taken_o     (pred_taken_o),
        .flush_o          (flush_o)
    );

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    // Three rising edges in reset, released on a falling edge
    initial begin
        rst_i = 1'b1;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
    end

    initial begin
        int    waited;
        bit    row_ok;
        case_t c;
        stall_i          = 1'b0;
        resolve_valid_i  = 1'b0;
        resolve_pc_i     = '0;
        resolve_taken_i  = 1'b0;
        resolve_pred_i   = 1'b0;
        resolve_target_i = '0;
        tests_run        = 0;
        tests_failed     = 0;
        waited           = 0;
        load_cases();

        while (rst_i !== 1'b0 && waited < RESET_TIMEOUT) begin
            @(negedge clk_i);
            #1;
            waited++;
        end

        if (rst_i !== 1'b0) begin
            $display("Timeout: reset still asserted after %0d cycles", waited);
            $display("*** FAILED ***");
            $finish;
        end else begin
            // PC sits at address 0 with nothing predicted
            row_ok = 1'b1;
            if (fetch_pc_o !== 32'h0) begin
                $display("ERROR reset_state: fetch_pc_o expected %h, actual %h", 32'h0, fetch_pc_o);
                row_ok = 1'b0;
            end
            if (pred_taken_o !== 1'b0 || flush_o !== 1'b0) begin
                $display("ERROR reset_state: pred/flush expected 0/0, actual %b/%b",
                         pred_taken_o, flush_o);
                row_ok = 1'b0;
            end
            tests_run++;
            if (row_ok) begin
                $display("ok   reset_state");
            end else begin
                tests_failed++;
                $display("fail reset_state");
            end

            for (int i = 0; i < cases.size(); i++) begin
                c      = cases[i];
                row_ok = 1'b1;
                @(negedge clk_i);
                stall_i          = c.stall;
                resolve_valid_i  = c.valid;
                resolve_pc_i     = c.pc;
                resolve_taken_i  = c.taken;
                resolve_pred_i   = c.pred;
                resolve_target_i = c.target;
                #10;
                if (flush_o !== c.exp_flush) begin
                    $display("ERROR %s: flush_o expected %b, actual %b",
                             case_names[i], c.exp_flush, flush_o);
                    row_ok = 1'b0;
                end
                @(posedge clk_i);
                #10;
                if (fetch_pc_o !== c.exp_pc) begin
                    $display("ERROR %s: fetch_pc_o expected %h, actual %h",
                             case_names[i], c.exp_pc, fetch_pc_o);
                    row_ok = 1'b0;
                end
                if (pred_taken_o !== c.exp_pred) begin
                    $display("ERROR %s: pred_taken_o expected %b, actual %b",
                             case_names[i], c.exp_pred, pred_taken_o);
                    row_ok = 1'b0;
                end
                tests_run++;
                if (row_ok) begin
                    $display("ok   %s", case_names[i]);
                end else begin
                    tests_failed++;
                    $display("fail %s", case_names[i]);
                end
            end

            @(negedge clk_i);
            stall_i         = 1'b0;
            resolve_valid_i = 1'b0;

            $display("Tests: %0d run, %0d passed, %0d failed",
                     tests_run, tests_run - tests_failed, tests_failed);
            if (tests_failed == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule
